// ==== verilog/vaddr_settings.svh ====
// vector address generator settings
// word and table widths, table depth and pipeline latencies
`ifndef VADDR_SETTINGS_SVH
`define VADDR_SETTINGS_SVH

// data path
`define VADDR_DATA_W 32
`define VADDR_SHIFT_W 5

// lookup tables
`define VADDR_LUT_AW 8
`define VADDR_LUT_DEPTH 256
`define VADDR_LUT_LAT 2

// command to output in enabled cycles
// stride, select/shift, add and final select are one cycle each
`define VADDR_LATENCY (4 + 2 * `VADDR_LUT_LAT)

`endif

// ==== verilog/vaddr_pkg.sv ====
// vector address generator types
// command, pipeline stage and table write records
`include "vaddr_settings.svh"

package vaddr_pkg;

	// one command from the vector unit
	typedef struct packed {
		logic start;
		logic [`VADDR_DATA_W-1:0] addr_base;
		logic [`VADDR_DATA_W-1:0] addr_step;
		logic [`VADDR_DATA_W-1:0] imm_base;
		logic [`VADDR_DATA_W-1:0] imm_step;
		logic [`VADDR_SHIFT_W-1:0] shift;
		logic reverse;
		logic lut0_en;
		logic lut1_en;
	} vaddr_cmd_t;

	// stride generator output
	typedef struct packed {
		logic valid;
		logic [`VADDR_DATA_W-1:0] addr;
		logic [`VADDR_DATA_W-1:0] imm;
		logic [`VADDR_SHIFT_W-1:0] shift;
		logic reverse;
		logic lut0_en;
		logic lut1_en;
	} vaddr_stage_t;

	// after shift and add
	typedef struct packed {
		logic valid;
		logic [`VADDR_DATA_W-1:0] addr;
		logic reverse;
		logic lut1_en;
	} vaddr_mid_t;

	// table write, sel picks table 0 or 1
	typedef struct packed {
		logic sel;
		logic [`VADDR_LUT_AW-1:0] idx;
		logic [`VADDR_DATA_W-1:0] data;
	} vaddr_lut_wr_t;

endpackage

// ==== verilog/vaddr_delay.sv ====
// clock-enabled delay line
// carries any packed payload DEPTH enabled cycles, cleared on reset
module vaddr_delay #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input  logic clk,
	input  logic reset,
	input  logic cke,
	input  T     din,
	output T     dout
);

	T chain [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				chain[i] <= '0;
			end
		end else if (cke) begin
			chain[0] <= din;
			// shift toward the output
			for (int i = 1; i < DEPTH; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	assign dout = chain[DEPTH-1];

endmodule

// ==== verilog/vaddr_lut.sv ====
// lookup table
// 256 words, direct write port, read pipelined over VADDR_LUT_LAT stages
`include "vaddr_settings.svh"

module vaddr_lut (
	input  logic clk,
	input  logic reset,
	input  logic cke,
	input  logic we,
	input  logic [`VADDR_LUT_AW-1:0] wr_idx,
	input  logic [`VADDR_DATA_W-1:0] wr_data,
	input  logic [`VADDR_LUT_AW-1:0] rd_idx,
	output logic [`VADDR_DATA_W-1:0] rd_data
);

	logic [`VADDR_DATA_W-1:0] mem [`VADDR_LUT_DEPTH];
	logic [`VADDR_DATA_W-1:0] rd_q [`VADDR_LUT_LAT];

	// writes ignore cke
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// read pipe, frozen with the rest of the datapath
	always_ff @(posedge clk) begin
		if (cke) begin
			rd_q[0] <= mem[rd_idx];
			for (int i = 1; i < `VADDR_LUT_LAT; i++) begin
				rd_q[i] <= rd_q[i-1];
			end
		end
	end

	assign rd_data = rd_q[`VADDR_LUT_LAT-1];

	// an unknown index would corrupt an arbitrary entry
	a_wr_idx_known: assert property (
		@(posedge clk) disable iff (reset)
		we |-> !$isunknown(wr_idx)
	);

endmodule

// ==== verilog/vaddr_step_gen.sv ====
// stride generator
// first pipeline stage, keeps the address and immediate accumulators
// and registers the per-command controls
module vaddr_step_gen (
	input  logic clk,
	input  logic reset,
	input  logic cke,
	input  logic cmd_valid,
	input  vaddr_pkg::vaddr_cmd_t cmd,
	output vaddr_pkg::vaddr_stage_t stage
);

	logic take;

	assign take = cke && cmd_valid;

	// ----------------------------------------------------------
	// accumulators and stage register
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			stage.valid <= 1'b0;
			stage.addr <= '0;
			stage.imm <= '0;
		end else if (cke) begin
			stage.valid <= cmd_valid;
			if (take) begin
				// start reloads, otherwise step on
				stage.addr <= cmd.start ? cmd.addr_base : stage.addr + cmd.addr_step;
				stage.imm <= cmd.start ? cmd.imm_base : stage.imm + cmd.imm_step;
				stage.shift <= cmd.shift;
				stage.reverse <= cmd.reverse;
				stage.lut0_en <= cmd.lut0_en;
				stage.lut1_en <= cmd.lut1_en;
			end
		end
	end

	// x in a taken command would poison the accumulators for good
	a_cmd_known: assert property (
		@(posedge clk) disable iff (reset)
		take |-> !$isunknown(cmd)
	);

endmodule

// ==== verilog/vaddr_index_pipe.sv ====
// index pipe
// table 0 lookup, shift, immediate add, optional index bit reversal,
// table 1 lookup and final select; seven enabled cycles deep
`include "vaddr_settings.svh"

module vaddr_index_pipe (
	input  logic clk,
	input  logic reset,
	input  logic cke,
	input  vaddr_pkg::vaddr_stage_t stage,
	input  logic lut0_we,
	input  logic lut1_we,
	input  vaddr_pkg::vaddr_lut_wr_t lut_wr,
	output logic out_valid,
	output logic [`VADDR_DATA_W-1:0] out_data
);
	import vaddr_pkg::*;

	// table index sits at bits 23:16
	localparam int IDX_LSB = 16;
	localparam int AW = `VADDR_LUT_AW;

	logic [`VADDR_DATA_W-1:0] lut0_data;
	logic [`VADDR_DATA_W-1:0] lut1_data;
	logic [`VADDR_DATA_W-1:0] sel_addr;
	logic [`VADDR_DATA_W-1:0] shf_imm;
	logic [AW-1:0] sum_idx;
	logic [AW-1:0] lut1_idx;
	vaddr_stage_t stage_d;
	vaddr_mid_t shf;
	vaddr_mid_t sum;
	vaddr_mid_t sum_d;

	// ----------------------------------------------------------
	// table 0 read with the stage fields alongside
	// ----------------------------------------------------------
	vaddr_lut u_lut0 (
		.clk     (clk),
		.reset   (reset),
		.cke     (cke),
		.we      (lut0_we),
		.wr_idx  (lut_wr.idx),
		.wr_data (lut_wr.data),
		.rd_idx  (stage.addr[IDX_LSB +: AW]),
		.rd_data (lut0_data)
	);

	vaddr_delay #(.T(vaddr_stage_t), .DEPTH(`VADDR_LUT_LAT)) u_side0 (
		.clk   (clk),
		.reset (reset),
		.cke   (cke),
		.din   (stage),
		.dout  (stage_d)
	);

	// ----------------------------------------------------------
	// select, shift, then add
	// ----------------------------------------------------------
	assign sel_addr = stage_d.lut0_en ? lut0_data : stage_d.addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			shf.valid <= 1'b0;
		end else if (cke) begin
			shf.valid <= stage_d.valid;
			shf.addr <= sel_addr << stage_d.shift;
			shf.reverse <= stage_d.reverse;
			shf.lut1_en <= stage_d.lut1_en;
			shf_imm <= stage_d.imm;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sum.valid <= 1'b0;
		end else if (cke) begin
			sum.valid <= shf.valid;
			sum.addr <= shf.addr + shf_imm;
			sum.reverse <= shf.reverse;
			sum.lut1_en <= shf.lut1_en;
		end
	end

	// ----------------------------------------------------------
	// table 1 read, index optionally bit-reversed
	// ----------------------------------------------------------
	assign sum_idx = sum.addr[IDX_LSB +: AW];

	always_comb begin
		lut1_idx = sum_idx;
		if (sum.reverse) begin
			for (int i = 0; i < AW; i++) begin
				lut1_idx[i] = sum_idx[AW-1-i];
			end
		end
	end

	vaddr_lut u_lut1 (
		.clk     (clk),
		.reset   (reset),
		.cke     (cke),
		.we      (lut1_we),
		.wr_idx  (lut_wr.idx),
		.wr_data (lut_wr.data),
		.rd_idx  (lut1_idx),
		.rd_data (lut1_data)
	);

	vaddr_delay #(.T(vaddr_mid_t), .DEPTH(`VADDR_LUT_LAT)) u_side1 (
		.clk   (clk),
		.reset (reset),
		.cke   (cke),
		.din   (sum),
		.dout  (sum_d)
	);

	// final select
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (cke) begin
			out_valid <= sum_d.valid;
			out_data <= sum_d.lut1_en ? lut1_data : sum_d.addr;
		end
	end

	// valid travels through two delay lines and three registers
	a_out_valid_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(out_valid)
	);

endmodule

// ==== verilog/vaddr_agu.sv ====
// vector address generator, top level
// stride generator feeding the index pipe, plus table write decode;
// one result per taken command, VADDR_LATENCY enabled cycles later
`include "vaddr_settings.svh"

module vaddr_agu (
	input  logic clk,
	input  logic reset,
	input  logic cke,
	input  logic cmd_valid,
	input  vaddr_pkg::vaddr_cmd_t cmd,
	input  logic lut_we,
	input  vaddr_pkg::vaddr_lut_wr_t lut_wr,
	output logic out_valid,
	output logic [`VADDR_DATA_W-1:0] out_data
);
	import vaddr_pkg::*;

	vaddr_stage_t stage;
	logic lut0_we;
	logic lut1_we;

	// ----------------------------------------------------------
	// table write decode
	// ----------------------------------------------------------
	assign lut0_we = lut_we && !lut_wr.sel;
	assign lut1_we = lut_we && lut_wr.sel;

	// ----------------------------------------------------------
	// pipeline
	// ----------------------------------------------------------
	vaddr_step_gen u_step_gen (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.stage     (stage)
	);

	// everything after the stride step
	vaddr_index_pipe u_index_pipe (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.stage     (stage),
		.lut0_we   (lut0_we),
		.lut1_we   (lut1_we),
		.lut_wr    (lut_wr),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// ==== verification/vaddr_agu_tb.sv ====
// vector address generator testbench
// random commands from a fixed seed, shadow tables and accumulators as
// the reference model, results checked in order with their latency
`include "vaddr_settings.svh"

module vaddr_agu_tb;
	import vaddr_pkg::*;

	localparam int LAT = `VADDR_LATENCY;

	logic clk = 1'b0;
	logic reset;
	logic cke;
	logic cmd_valid;
	vaddr_cmd_t cmd;
	logic lut_we;
	vaddr_lut_wr_t lut_wr;
	logic out_valid;
	logic [31:0] out_data;

	logic [31:0] seed = 32'hf29c;
	logic [31:0] lut0_model [256];
	logic [31:0] lut1_model [256];
	logic [31:0] acc_addr;
	logic [31:0] acc_imm;
	logic [31:0] exp_q [$];
	int take_q [$];
	int en_edges = 0;
	logic last_en = 1'b0;
	int mismatch_cnt = 0;
	int stray_cnt = 0;
	int timeout_cnt = 0;
	string test_name = "reset_idle";

	vaddr_agu u_vaddr_agu (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.lut_we    (lut_we),
		.lut_wr    (lut_wr),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// controls come from the upper LCG bits
	function automatic vaddr_cmd_t random_cmd();
		vaddr_cmd_t c;
		logic [31:0] r;
		r = lcg_next();
		c.start = (r[31:29] == 3'd0);
		c.shift = r[27:23];
		c.reverse = r[22];
		c.lut0_en = r[21];
		c.lut1_en = r[20];
		c.addr_base = lcg_next();
		c.addr_step = lcg_next();
		c.imm_base = lcg_next();
		c.imm_step = lcg_next();
		return c;
	endfunction

	// expected result from the already stepped accumulators
	function automatic logic [31:0] expect_result(input vaddr_cmd_t c, input logic [31:0] addr,
		input logic [31:0] imm);
		logic [31:0] a;
		logic [31:0] s;
		logic [7:0] idx;
		logic [7:0] rev;
		a = c.lut0_en ? lut0_model[addr[23:16]] : addr;
		s = (a << c.shift) + imm;
		idx = s[23:16];
		rev = {<<{idx}};
		if (c.reverse) begin
			idx = rev;
		end
		return c.lut1_en ? lut1_model[idx] : s;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			mismatch_cnt++;
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d stray outputs, %0d timeouts",
			mismatch_cnt, stray_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && stray_cnt == 0 && timeout_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	task automatic drive_cycle(input logic valid, input vaddr_cmd_t c, input logic en);
		@(posedge clk);
		cmd_valid <= valid;
		cmd <= c;
		cke <= en;
		lut_we <= 1'b0;
	endtask

	task automatic write_lut(input logic sel, input logic [7:0] idx, input logic [31:0] data);
		vaddr_lut_wr_t w;
		w.sel = sel;
		w.idx = idx;
		w.data = data;
		@(posedge clk);
		cmd_valid <= 1'b0;
		lut_we <= 1'b1;
		lut_wr <= w;
		if (sel) begin
			lut1_model[idx] = data;
		end else begin
			lut0_model[idx] = data;
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			drive_cycle(1'b0, '0, 1'b1);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout in %s: %0d results still missing after %0d cycles",
				test_name, exp_q.size(), limit);
			timeout_cnt++;
			// forget the missing results
			exp_q.delete();
			take_q.delete();
		end
	endtask

	// ----------------------------------------------------------
	// monitor and reference model on the falling edge
	// ----------------------------------------------------------
	always @(negedge clk) begin
		int stamp;
		if (reset) begin
			acc_addr = '0;
			acc_imm = '0;
		end else begin
			// a new result only after an enabled edge
			if (last_en) begin
				en_edges++;
				if (out_valid && exp_q.size() == 0) begin
					$display("out_valid high in %s with no command in flight", test_name);
					stray_cnt++;
				end else if (out_valid) begin
					check({test_name, " data"}, exp_q.pop_front(), out_data);
					stamp = take_q.pop_front();
					check({test_name, " latency"}, 32'(LAT), 32'(en_edges - stamp));
				end
			end
			if (cke && cmd_valid) begin
				acc_addr = cmd.start ? cmd.addr_base : acc_addr + cmd.addr_step;
				acc_imm = cmd.start ? cmd.imm_base : acc_imm + cmd.imm_step;
				exp_q.push_back(expect_result(cmd, acc_addr, acc_imm));
				take_q.push_back(en_edges);
			end
		end
		last_en = cke && !reset;
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		vaddr_cmd_t c;
		logic [31:0] r;
		int span;
		reset = 1'b1;
		cke = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		lut_we = 1'b0;
		lut_wr = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (20) drive_cycle(1'b0, '0, 1'b1);

		test_name = "plain_stride";
		for (int i = 0; i < 24; i++) begin
			c = random_cmd();
			c.start = (i == 0 || i == 13);
			c.shift = '0;
			c.imm_base = '0;
			c.imm_step = '0;
			c.lut0_en = 1'b0;
			c.lut1_en = 1'b0;
			drive_cycle(1'b1, c, 1'b1);
		end
		wait_drain(100);

		// both tables full of random words
		for (int i = 0; i < 256; i++) begin
			write_lut(1'b0, 8'(i), lcg_next());
			write_lut(1'b1, 8'(i), lcg_next());
		end
		drive_cycle(1'b0, '0, 1'b1);

		test_name = "lut0_shift_imm";
		for (int i = 0; i < 40; i++) begin
			c = random_cmd();
			c.lut0_en = 1'b1;
			c.lut1_en = 1'b0;
			drive_cycle(1'b1, c, 1'b1);
		end
		wait_drain(100);

		test_name = "lut1_reverse";
		for (int i = 0; i < 40; i++) begin
			c = random_cmd();
			c.lut1_en = 1'b1;
			drive_cycle(1'b1, c, 1'b1);
		end
		wait_drain(100);

		test_name = "cke_stall";
		for (int i = 0; i < 150; i++) begin
			r = lcg_next();
			if (r[31:30] == 2'b00) begin
				span = 1 + int'(r[26:24]);
				// commands offered during a stall are not taken
				for (int j = 0; j < span; j++) begin
					drive_cycle(r[20], random_cmd(), 1'b0);
				end
			end
			drive_cycle(1'b1, random_cmd(), 1'b1);
		end
		wait_drain(200);

		// new contents at table 0 entries 0x40..0x4f and all of table 1
		test_name = "lut_rewrite";
		for (int i = 0; i < 16; i++) begin
			write_lut(1'b0, 8'(8'h40 + i), lcg_next());
		end
		for (int i = 0; i < 256; i++) begin
			write_lut(1'b1, 8'(i), lcg_next());
		end
		drive_cycle(1'b0, '0, 1'b1);
		for (int i = 0; i < 32; i++) begin
			c = random_cmd();
			c.start = (i == 0 || i == 16);
			c.addr_base = 32'h0040_0000;
			c.addr_step = 32'h0001_0000;
			c.lut0_en = 1'b1;
			drive_cycle(1'b1, c, 1'b1);
		end
		wait_drain(100);
		repeat (10) drive_cycle(1'b0, '0, 1'b1);
		finish_run();
	end

endmodule

// ==== vaddr_agu.f ====
+incdir+verilog
verilog/vaddr_pkg.sv
verilog/vaddr_delay.sv
verilog/vaddr_lut.sv
verilog/vaddr_step_gen.sv
verilog/vaddr_index_pipe.sv
verilog/vaddr_agu.sv
verification/vaddr_agu_tb.sv

// ==== Makefile ====
# Verilator build for the vector address generator testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = vaddr_agu_tb
FILELIST  = vaddr_agu.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
